//--- hdl/iq_pkg.sv
package iq_pkg;

    ////////////////////////////////////////
    // sizes
    ////////////////////////////////////////
    localparam int RS_DEPTH = 8;
    localparam int RS_IDX_W = 3;
    localparam int REG_W    = 6;
    localparam int REG_NUM  = 64;
    localparam int FU_NUM   = 3;
    localparam int FU_W     = 2;
    localparam int ROB_W    = 6;
    localparam int XLEN     = 32;
    localparam int OP_W     = 4;

    // riscv major opcodes
    localparam logic [6:0] OPC_RTYPE = 7'b0110011;
    localparam logic [6:0] OPC_ITYPE = 7'b0010011;
    localparam logic [6:0] OPC_LUI   = 7'b0110111;
    localparam logic [6:0] OPC_LOAD  = 7'b0000011;
    localparam logic [6:0] OPC_STORE = 7'b0100011;

    typedef logic [OP_W-1:0] op_t;

    // internal operation codes, 0 is unknown
    localparam op_t OP_NONE = 4'd0;
    localparam op_t OP_ADD  = 4'd1;
    localparam op_t OP_ADDI = 4'd2;
    localparam op_t OP_LUI  = 4'd3;
    localparam op_t OP_ORI  = 4'd4;
    localparam op_t OP_XOR  = 4'd5;
    localparam op_t OP_SRAI = 4'd6;
    localparam op_t OP_LB   = 4'd7;
    localparam op_t OP_LW   = 4'd8;
    localparam op_t OP_SB   = 4'd9;
    localparam op_t OP_SW   = 4'd10;

    ////////////////////////////////////////
    // structs
    ////////////////////////////////////////

    // renamed instruction from dispatch
    typedef struct packed {
        logic [6:0]       opcode;
        logic [2:0]       funct3;
        logic [REG_W-1:0] rs1;
        logic [XLEN-1:0]  rs1_val;
        logic [REG_W-1:0] rs2;
        logic [XLEN-1:0]  rs2_val;
        logic [XLEN-1:0]  imm;
        logic [REG_W-1:0] rd;
        logic [XLEN-1:0]  pc;
    } dispatch_t;

    // one result broadcast per unit
    typedef struct packed {
        logic             valid;
        logic [REG_W-1:0] tag;
        logic [XLEN-1:0]  value;
    } result_t;

    typedef struct packed {
        logic             valid;
        op_t              op;
        logic [REG_W-1:0] rd;
        logic [REG_W-1:0] src1;
        logic             src1_rdy;
        logic [XLEN-1:0]  src1_data;
        logic [REG_W-1:0] src2;
        logic             src2_rdy;
        logic [XLEN-1:0]  src2_data;
        logic [XLEN-1:0]  imm;
        logic [FU_W-1:0]  fu;
        logic [ROB_W-1:0] rob;
        logic [XLEN-1:0]  pc;
    } rs_entry_t;

    typedef struct packed {
        op_t              op;
        logic [REG_W-1:0] rd;
        logic [XLEN-1:0]  src1_val;
        logic [XLEN-1:0]  src2_val;
        logic [XLEN-1:0]  imm;
        logic [FU_W-1:0]  fu;
        logic [ROB_W-1:0] rob;
        logic [XLEN-1:0]  pc;
    } issue_t;

endpackage

//--- hdl/op_decode.sv
`timescale 1ns/1ps

module op_decode (
    input  logic        [6:0] opcode,
    input  logic        [2:0] funct3,
    output iq_pkg::op_t       op,
    output logic              force_src1,
    output logic              force_src2
);
    import iq_pkg::*;

    always_comb begin
        op = OP_NONE;
        case (opcode)
            OPC_RTYPE: begin
                case (funct3)
                    3'b000:  op = OP_ADD;
                    3'b100:  op = OP_XOR;
                    default: op = OP_NONE;
                endcase
            end
            OPC_ITYPE: begin
                case (funct3)
                    3'b000:  op = OP_ADDI;
                    3'b101:  op = OP_SRAI;
                    3'b110:  op = OP_ORI;
                    default: op = OP_NONE;
                endcase
            end
            OPC_LUI: op = OP_LUI;
            OPC_LOAD: begin
                case (funct3)
                    3'b000:  op = OP_LB;
                    3'b010:  op = OP_LW;
                    default: op = OP_NONE;
                endcase
            end
            OPC_STORE: begin
                case (funct3)
                    3'b000:  op = OP_SB;
                    3'b010:  op = OP_SW;
                    default: op = OP_NONE;
                endcase
            end
            default: op = OP_NONE;
        endcase
    end

    // lui reads no register, loads have no rs2
    assign force_src1 = (op == OP_LUI);
    assign force_src2 = (op == OP_LUI) || (op == OP_LB) || (op == OP_LW);

endmodule

//--- hdl/dispatch_tagger.sv
`timescale 1ns/1ps

module dispatch_tagger (
    input  logic                     clk,
    input  logic                     rstn,
    input  logic                     accept,
    output logic [iq_pkg::ROB_W-1:0] rob_no,
    output logic [iq_pkg::FU_W-1:0]  fu_no
);
    import iq_pkg::*;

    logic [ROB_W-1:0] rob_q;
    logic [FU_W-1:0]  fu_q;

    // rob number wraps 63 -> 0 on its own
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            rob_q <= '0;
        end else if (accept) begin
            rob_q <= rob_q + ROB_W'(1);
        end
    end

    // round robin over the units
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            fu_q <= '0;
        end else if (accept) begin
            if (fu_q == FU_W'(FU_NUM - 1)) begin
                fu_q <= '0;
            end else begin
                fu_q <= fu_q + FU_W'(1);
            end
        end
    end

    // current values go with the instruction being accepted
    assign rob_no = rob_q;
    assign fu_no  = fu_q;

endmodule

//--- hdl/rs_array.sv
`timescale 1ns/1ps

module rs_array (
    input  logic                                     clk,
    input  logic                                     rstn,
    input  logic                                     dispatch,
    input  iq_pkg::dispatch_t                        disp,
    input  iq_pkg::op_t                              op,
    input  logic                                     force_src1,
    input  logic                                     force_src2,
    input  logic [iq_pkg::REG_NUM-1:0]               rob_ready,
    input  iq_pkg::result_t [iq_pkg::FU_NUM-1:0]     results,
    input  logic [iq_pkg::ROB_W-1:0]                 rob_no,
    input  logic [iq_pkg::FU_W-1:0]                  fu_no,
    input  logic [iq_pkg::RS_DEPTH-1:0]              clear,
    output iq_pkg::rs_entry_t [iq_pkg::RS_DEPTH-1:0] entries,
    output logic                                     accept,
    output logic                                     full
);
    import iq_pkg::*;

    rs_entry_t [RS_DEPTH-1:0]         ent_q;
    rs_entry_t                        new_ent;
    logic [RS_DEPTH-1:0]              occupied;
    logic [RS_IDX_W-1:0]              free_idx;
    // {hit, value} from the result buses
    logic [XLEN:0]                    disp_hit1;
    logic [XLEN:0]                    disp_hit2;
    logic [RS_DEPTH-1:0][XLEN:0]      wake1;
    logic [RS_DEPTH-1:0][XLEN:0]      wake2;

    // lowest numbered matching bus wins
    function automatic logic [XLEN:0] snoop(
        input logic [REG_W-1:0]     tag,
        input result_t [FU_NUM-1:0] res
    );
        logic [XLEN:0] hit;
        hit = '0;
        for (int b = FU_NUM - 1; b >= 0; b--) begin
            if (res[b].valid && (res[b].tag == tag)) begin
                hit = {1'b1, res[b].value};
            end
        end
        return hit;
    endfunction

    ////////////////////////////////////////
    // free slot and dispatch capture
    ////////////////////////////////////////
    always_comb begin
        for (int i = 0; i < RS_DEPTH; i++) begin
            occupied[i] = ent_q[i].valid;
        end
    end

    assign full   = &occupied;
    assign accept = dispatch && !full;

    always_comb begin
        free_idx = '0;
        for (int i = RS_DEPTH - 1; i >= 0; i--) begin
            if (!occupied[i]) begin
                free_idx = RS_IDX_W'(i);
            end
        end
    end

    assign disp_hit1 = snoop(disp.rs1, results);
    assign disp_hit2 = snoop(disp.rs2, results);

    always_comb begin
        new_ent       = '0;
        new_ent.valid = 1'b1;
        new_ent.op    = op;
        new_ent.rd    = disp.rd;
        new_ent.src1  = disp.rs1;
        new_ent.src2  = disp.rs2;
        new_ent.imm   = disp.imm;
        new_ent.fu    = fu_no;
        new_ent.rob   = rob_no;
        new_ent.pc    = disp.pc;

        // bus first, then register file, then forced zero
        if (disp_hit1[XLEN]) begin
            new_ent.src1_rdy  = 1'b1;
            new_ent.src1_data = disp_hit1[XLEN-1:0];
        end else if (rob_ready[disp.rs1]) begin
            new_ent.src1_rdy  = 1'b1;
            new_ent.src1_data = disp.rs1_val;
        end else if (force_src1) begin
            new_ent.src1_rdy  = 1'b1;
        end

        if (disp_hit2[XLEN]) begin
            new_ent.src2_rdy  = 1'b1;
            new_ent.src2_data = disp_hit2[XLEN-1:0];
        end else if (rob_ready[disp.rs2]) begin
            new_ent.src2_rdy  = 1'b1;
            new_ent.src2_data = disp.rs2_val;
        end else if (force_src2) begin
            new_ent.src2_rdy  = 1'b1;
        end
    end

    ////////////////////////////////////////
    // wakeup of stored entries
    ////////////////////////////////////////
    always_comb begin
        for (int i = 0; i < RS_DEPTH; i++) begin
            wake1[i] = snoop(ent_q[i].src1, results);
            wake2[i] = snoop(ent_q[i].src2, results);
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            ent_q <= '0;
        end else begin
            for (int i = 0; i < RS_DEPTH; i++) begin
                if (clear[i]) begin
                    ent_q[i].valid <= 1'b0;
                end else if (ent_q[i].valid) begin
                    if (!ent_q[i].src1_rdy && wake1[i][XLEN]) begin
                        ent_q[i].src1_rdy  <= 1'b1;
                        ent_q[i].src1_data <= wake1[i][XLEN-1:0];
                    end
                    if (!ent_q[i].src2_rdy && wake2[i][XLEN]) begin
                        ent_q[i].src2_rdy  <= 1'b1;
                        ent_q[i].src2_data <= wake2[i][XLEN-1:0];
                    end
                end
            end
            // target slot is free, so no clash with the loop above
            if (accept) begin
                ent_q[free_idx] <= new_ent;
            end
        end
    end

    assign entries = ent_q;

endmodule

//--- hdl/issue_select.sv
`timescale 1ns/1ps

module issue_select (
    input  logic                                     clk,
    input  logic                                     rstn,
    input  iq_pkg::rs_entry_t [iq_pkg::RS_DEPTH-1:0] entries,
    input  logic [iq_pkg::FU_NUM-1:0]                fu_ready,
    output logic [iq_pkg::RS_DEPTH-1:0]              clear,
    output iq_pkg::issue_t [iq_pkg::FU_NUM-1:0]      issue_bus,
    output logic [iq_pkg::FU_NUM-1:0]                issue_valid,
    output logic                                     no_issue
);
    import iq_pkg::*;

    logic [FU_NUM-1:0][RS_DEPTH-1:0] ready_mask;
    logic [FU_NUM-1:0]               pick_hit;
    logic [FU_NUM-1:0][RS_IDX_W-1:0] pick_idx;

    function automatic issue_t to_issue(input rs_entry_t e);
        issue_t b;
        b.op       = e.op;
        b.rd       = e.rd;
        b.src1_val = e.src1_data;
        b.src2_val = e.src2_data;
        b.imm      = e.imm;
        b.fu       = e.fu;
        b.rob      = e.rob;
        b.pc       = e.pc;
        return b;
    endfunction

    // per unit: valid, both operands in, bound to that unit
    always_comb begin
        for (int u = 0; u < FU_NUM; u++) begin
            for (int i = 0; i < RS_DEPTH; i++) begin
                ready_mask[u][i] = entries[i].valid && entries[i].src1_rdy &&
                                   entries[i].src2_rdy && (entries[i].fu == FU_W'(u));
            end
        end
    end

    // lowest index wins, only where the unit takes work
    always_comb begin
        pick_hit = '0;
        pick_idx = '0;
        clear    = '0;
        for (int u = 0; u < FU_NUM; u++) begin
            for (int i = RS_DEPTH - 1; i >= 0; i--) begin
                if (fu_ready[u] && ready_mask[u][i]) begin
                    pick_hit[u] = 1'b1;
                    pick_idx[u] = RS_IDX_W'(i);
                end
            end
        end
        // entry leaves the array at the same edge the bus loads
        for (int u = 0; u < FU_NUM; u++) begin
            if (pick_hit[u]) begin
                clear[pick_idx[u]] = 1'b1;
            end
        end
    end

    ////////////////////////////////////////
    // issue register stage
    ////////////////////////////////////////
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            issue_valid <= '0;
            no_issue    <= 1'b1;
        end else begin
            issue_valid <= pick_hit;
            no_issue    <= ~|pick_hit;
        end
    end

    always_ff @(posedge clk) begin
        for (int u = 0; u < FU_NUM; u++) begin
            if (pick_hit[u]) begin
                issue_bus[u] <= to_issue(entries[pick_idx[u]]);
            end
        end
    end

endmodule

//--- hdl/issue_queue_top.sv
`timescale 1ns/1ps

module issue_queue_top (
    input  logic                                 clk,
    input  logic                                 rstn,
    input  logic                                 dispatch,
    input  iq_pkg::dispatch_t                    disp,
    input  logic [iq_pkg::REG_NUM-1:0]           rob_ready,
    input  iq_pkg::result_t [iq_pkg::FU_NUM-1:0] results,
    input  logic [iq_pkg::FU_NUM-1:0]            fu_ready,
    output iq_pkg::issue_t [iq_pkg::FU_NUM-1:0]  issue_bus,
    output logic [iq_pkg::FU_NUM-1:0]            issue_valid,
    output logic                                 no_issue,
    output logic                                 full
);
    import iq_pkg::*;

    op_t                      dec_op;
    logic                     force_src1;
    logic                     force_src2;
    logic                     accept;
    logic [ROB_W-1:0]         rob_no;
    logic [FU_W-1:0]          fu_no;
    rs_entry_t [RS_DEPTH-1:0] entries;
    logic [RS_DEPTH-1:0]      clear;

    op_decode u_decode (
        .opcode     (disp.opcode),
        .funct3     (disp.funct3),
        .op         (dec_op),
        .force_src1 (force_src1),
        .force_src2 (force_src2)
    );

    dispatch_tagger u_tagger (
        .clk    (clk),
        .rstn   (rstn),
        .accept (accept),
        .rob_no (rob_no),
        .fu_no  (fu_no)
    );

    rs_array u_rs (
        .clk        (clk),
        .rstn       (rstn),
        .dispatch   (dispatch),
        .disp       (disp),
        .op         (dec_op),
        .force_src1 (force_src1),
        .force_src2 (force_src2),
        .rob_ready  (rob_ready),
        .results    (results),
        .rob_no     (rob_no),
        .fu_no      (fu_no),
        .clear      (clear),
        .entries    (entries),
        .accept     (accept),
        .full       (full)
    );

    issue_select u_select (
        .clk         (clk),
        .rstn        (rstn),
        .entries     (entries),
        .fu_ready    (fu_ready),
        .clear       (clear),
        .issue_bus   (issue_bus),
        .issue_valid (issue_valid),
        .no_issue    (no_issue)
    );

endmodule

//--- testbench/tb_issue_queue.sv
`timescale 1ns/1ps

module tb_issue_queue;
    import iq_pkg::*;

    typedef struct {
        int          op;
        int          fu;
        logic [5:0]  rd;
        logic [31:0] pc;
        logic [31:0] imm;
        logic [31:0] v1;
        logic [31:0] v2;
        bit          p1;
        bit          p2;
        logic [5:0]  t1;
        logic [5:0]  t2;
    } rec_t;

    logic                       clk;
    logic                       rstn;
    logic                       dispatch;
    dispatch_t                  disp;
    logic [REG_NUM-1:0]         rob_ready;
    result_t [FU_NUM-1:0]       results;
    logic [FU_NUM-1:0]          fu_ready;
    issue_t [FU_NUM-1:0]        issue_bus;
    logic [FU_NUM-1:0]          issue_valid;
    logic                       no_issue;
    logic                       full;

    rec_t        rec[int];
    int          exp_rob;
    int          exp_fu;
    integer      seed;
    logic [31:0] rf_val[REG_NUM];
    logic [FU_NUM-1:0] fu_rdy_last;

    // ADD ADDI LUI ORI XOR SRAI LB LW SB SW as codes 1 to 10
    logic [6:0] opc_tab[10] = '{7'h33, 7'h13, 7'h37, 7'h13, 7'h33,
                                7'h13, 7'h03, 7'h03, 7'h23, 7'h23};
    logic [2:0] f3_tab[10]  = '{3'd0, 3'd0, 3'd0, 3'd6, 3'd4, 3'd5, 3'd0, 3'd2, 3'd0, 3'd2};

    issue_queue_top u_dut (
        .clk         (clk),
        .rstn        (rstn),
        .dispatch    (dispatch),
        .disp        (disp),
        .rob_ready   (rob_ready),
        .results     (results),
        .fu_ready    (fu_ready),
        .issue_bus   (issue_bus),
        .issue_valid (issue_valid),
        .no_issue    (no_issue),
        .full        (full)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic report_fail(input string msg);
        $display("FAIL %0t: %s", $time, msg);
        $display("Simulation finished: FAIL");
        $fatal(1, "stopped at first error");
    endtask

    // expected source by dispatch priority of bus, register file and forced zero
    task automatic expect_src(input logic [5:0] tag, input bit frc,
                              output bit pend, output logic [31:0] val);
        pend = 1'b0;
        val  = '0;
        for (int b = FU_NUM - 1; b >= 0; b--) begin
            if (results[b].valid && results[b].tag == tag) begin
                val = results[b].value;
            end
        end
        if (results[0].valid && results[0].tag == tag || results[1].valid &&
            results[1].tag == tag || results[2].valid && results[2].tag == tag) begin
            pend = 1'b0;
        end else if (rob_ready[tag]) begin
            val = rf_val[tag];
        end else if (!frc) begin
            pend = 1'b1;
        end
    endtask

    assert property (@(posedge clk) disable iff (!rstn) no_issue == (issue_valid == '0))
        else report_fail("no_issue disagrees with issue_valid");

    ////////////////////////////////////////
    // reference model and issue checks
    ////////////////////////////////////////
    always @(negedge clk) begin
        int  k;
        int  idx;
        rec_t r;
        if (rstn) begin
            for (int u = 0; u < FU_NUM; u++) begin
                if (issue_valid[u]) begin
                    k = int'(issue_bus[u].rob);
                    assert (fu_rdy_last[u]) else report_fail("issue on a stalled unit");
                    assert (rec.exists(k)) else report_fail("issue of unknown rob number");
                    r = rec[k];
                    assert (!r.p1 && !r.p2) else report_fail("issue before wakeup");
                    assert (r.fu == u) else report_fail("wrong unit");
                    assert (int'(issue_bus[u].fu) == r.fu)
                        else report_fail("wrong unit field");
                    assert (int'(issue_bus[u].op) == r.op) else report_fail("wrong op");
                    assert (issue_bus[u].rd == r.rd) else report_fail("wrong rd");
                    assert (issue_bus[u].pc == r.pc) else report_fail("wrong pc");
                    assert (issue_bus[u].imm == r.imm) else report_fail("wrong imm");
                    assert (issue_bus[u].src1_val == r.v1) else report_fail("wrong src1");
                    assert (issue_bus[u].src2_val == r.v2) else report_fail("wrong src2");
                    rec.delete(k);
                end
            end
            // waiting records wake up with bus 0 first
            foreach (rec[j]) begin
                for (int b = FU_NUM - 1; b >= 0; b--) begin
                    if (results[b].valid && rec[j].p1 && results[b].tag == rec[j].t1) begin
                        rec[j].v1 = results[b].value;
                    end
                    if (results[b].valid && rec[j].p2 && results[b].tag == rec[j].t2) begin
                        rec[j].v2 = results[b].value;
                    end
                end
                for (int b = 0; b < FU_NUM; b++) begin
                    if (results[b].valid && results[b].tag == rec[j].t1) rec[j].p1 = 1'b0;
                    if (results[b].valid && results[b].tag == rec[j].t2) rec[j].p2 = 1'b0;
                end
            end
            if (dispatch && !full) begin
                idx = 0;
                for (int i = 0; i < 10; i++) begin
                    if (opc_tab[i] == disp.opcode && f3_tab[i] == disp.funct3) idx = i;
                end
                assert (!rec.exists(exp_rob)) else report_fail("rob number reused early");
                r.op  = idx + 1;
                r.fu  = exp_fu;
                r.rd  = disp.rd;
                r.pc  = disp.pc;
                r.imm = disp.imm;
                r.t1  = disp.rs1;
                r.t2  = disp.rs2;
                expect_src(disp.rs1, idx == 2, r.p1, r.v1);
                expect_src(disp.rs2, idx == 2 || idx == 6 || idx == 7, r.p2, r.v2);
                rec[exp_rob] = r;
                exp_rob = (exp_rob + 1) % 64;
                exp_fu  = (exp_fu + 1) % FU_NUM;
            end
        end else begin
            assert (issue_valid == '0 && no_issue && !full) else report_fail("bad reset outputs");
        end
        fu_rdy_last = fu_ready;
    end

    // one dispatch strobe with an optional broadcast in the same cycle
    task automatic send(input int idx, input logic [5:0] rs1, input logic [5:0] rs2,
                        input bit bc, input int bus, input logic [5:0] tag,
                        input logic [31:0] val);
        @(posedge clk);
        dispatch     <= 1'b1;
        disp.opcode  <= opc_tab[idx];
        disp.funct3  <= f3_tab[idx];
        disp.rs1     <= rs1;
        disp.rs1_val <= rf_val[rs1];
        disp.rs2     <= rs2;
        disp.rs2_val <= rf_val[rs2];
        disp.imm     <= $random(seed);
        disp.rd      <= REG_W'($random(seed));
        disp.pc      <= $random(seed);
        if (bc) results[bus] <= '{valid: 1'b1, tag: tag, value: val};
        @(posedge clk);
        dispatch <= 1'b0;
        for (int b = 0; b < FU_NUM; b++) results[b].valid <= 1'b0;
    endtask

    task automatic broadcast(input int bus, input logic [5:0] tag, input logic [31:0] val);
        @(posedge clk);
        results[bus] <= '{valid: 1'b1, tag: tag, value: val};
        @(posedge clk);
        results[bus].valid <= 1'b0;
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while (rec.size() != 0) begin
            @(posedge clk);
            n++;
            if (n > 300) begin
                $display("timeout: queue did not drain, %0d left", rec.size());
                $display("Simulation finished: FAIL");
                $fatal(1, "drain timeout");
            end
        end
    endtask

    initial begin
        seed      = 78;
        exp_rob   = 0;
        exp_fu    = 0;
        rstn      = 1'b0;
        dispatch  = 1'b0;
        disp      = '0;
        rob_ready = '0;
        results   = '0;
        fu_ready  = '1;
        fu_rdy_last = '1;
        for (int i = 0; i < REG_NUM; i++) rf_val[i] = $random(seed);
        repeat (16) @(posedge clk);
        rstn <= 1'b1;
        repeat (2) @(posedge clk);

        // enough independent ops to wrap the rob counter
        rob_ready <= '1;
        for (int i = 0; i < 70; i++) begin
            send($unsigned($random(seed)) % 10, REG_W'($random(seed)),
                 REG_W'($random(seed)), 0, 0, 0, 0);
        end
        wait_drain();

        // forced sources with nothing ready in the register file
        rob_ready     <= '0;
        rob_ready[5]  <= 1'b1;
        send(2, 6'd40, 6'd41, 0, 0, 0, 0);
        send(7, 6'd5, 6'd42, 0, 0, 0, 0);
        send(6, 6'd5, 6'd43, 0, 0, 0, 0);
        wait_drain();

        // wakeup from later and same cycle broadcasts
        rob_ready <= '0;
        send(0, 6'd10, 6'd11, 0, 0, 0, 0);
        repeat (4) @(posedge clk);
        broadcast(2, 6'd10, 32'h1234_5678);
        @(posedge clk);
        results[0] <= '{valid: 1'b1, tag: 6'd11, value: 32'h0bad_cafe};
        results[1] <= '{valid: 1'b1, tag: 6'd11, value: 32'hdead_beef};
        @(posedge clk);
        results[0].valid <= 1'b0;
        results[1].valid <= 1'b0;
        send(4, 6'd20, 6'd21, 1, 1, 6'd20, 32'h5555_aaaa);
        repeat (3) @(posedge clk);
        broadcast(0, 6'd21, 32'h0f0f_0f0f);
        wait_drain();

        // back-pressure until full and one dropped dispatch
        rob_ready <= '1;
        fu_ready  <= '0;
        for (int i = 0; i < 9; i++) begin
            send(0, REG_W'($random(seed)), REG_W'($random(seed)), 0, 0, 0, 0);
        end
        @(negedge clk);
        assert (full) else report_fail("full not set with 8 held entries");
        assert (rec.size() == 8) else report_fail("dropped dispatch was recorded");
        repeat (4) @(posedge clk);
        fu_ready <= '1;
        wait_drain();

        // the dropped dispatch left the rob and unit counters alone
        send(1, 6'd1, 6'd2, 0, 0, 0, 0);
        wait_drain();
        repeat (4) @(posedge clk);

        $display("Simulation finished: PASS");
        $finish;
    end

    // hard limit on the whole run
    initial begin
        #200000;
        $display("timeout: simulation ran past its time limit");
        $display("Simulation finished: FAIL");
        $fatal(1, "global timeout");
    end

endmodule

//--- files.f
hdl/iq_pkg.sv
hdl/op_decode.sv
hdl/dispatch_tagger.sv
hdl/rs_array.sv
hdl/issue_select.sv
hdl/issue_queue_top.sv
testbench/tb_issue_queue.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_issue_queue
FILELIST = files.f
LOG      = sim.log
OBJ      = obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run and check the log"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ)
	-./$(OBJ)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Simulation finished: FAIL" $(LOG); then \
		echo "test failed"; exit 1; \
	fi
	@grep -q "Simulation finished: PASS" $(LOG) || (echo "no result in log"; exit 1)

clean:
	rm -rf $(OBJ) $(LOG)
